//--- common/mipsPkg.sv
`default_nettype none

package mipsPkg;

    ////////////////////
    // widths with a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [3:0] aluCtrl_t;
    typedef logic [1:0] aluOp_t;
    typedef logic [1:0] forwardSel_t;

    // load port handshake states
    typedef enum logic [1:0] {
        LoadIdle,
        LoadWrite,
        LoadAck
    } loadState_t;

    ////////////////////
    // opcodes
    localparam opcode_t OpRType = 6'd0;
    localparam opcode_t OpBeq = 6'd4;
    localparam opcode_t OpBne = 6'd5;
    localparam opcode_t OpLw = 6'd35;
    localparam opcode_t OpSw = 6'd43;

    // R-format function field
    localparam funct_t FunctAdd = 6'd32;
    localparam funct_t FunctSub = 6'd34;
    localparam funct_t FunctAnd = 6'd36;
    localparam funct_t FunctOr = 6'd37;
    localparam funct_t FunctSlt = 6'd42;

    // ALU operation codes
    localparam aluCtrl_t AluAnd = 4'd0;
    localparam aluCtrl_t AluOr = 4'd1;
    localparam aluCtrl_t AluAdd = 4'd2;
    localparam aluCtrl_t AluSub = 4'd6;
    localparam aluCtrl_t AluSlt = 4'd7;

    // instruction class from decoder to ALU control
    localparam aluOp_t AluOpMem = 2'd0;
    localparam aluOp_t AluOpBranch = 2'd1;
    localparam aluOp_t AluOpRType = 2'd2;

    // operand source in execute
    localparam forwardSel_t FwdReg = 2'd0;
    localparam forwardSel_t FwdWb = 2'd1;
    localparam forwardSel_t FwdMem = 2'd2;

    ////////////////////
    // memory sizes, word indexed
    localparam int InstrDepth = 64;
    localparam int DataDepth = 64;
    localparam int InstrAddrBits = 6;
    localparam int DataAddrBits = 6;

endpackage

`default_nettype wire

//--- decode/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
    input wire clock,
    input wire WriteEnable,
    input wire mipsPkg::word_t idInstruction,
    input wire mipsPkg::word_t idPcPlusFour,
    input wire flush,
    input wire wbRegWrite,
    input wire mipsPkg::regAddr_t wbWriteAddress,
    input wire mipsPkg::word_t wbData,
    output logic stall,
    output logic exRegWrite,
    output logic exMemRead,
    output logic exMemWrite,
    output logic exBranch,
    output logic exBranchNot,
    output logic exAluSrc,
    output mipsPkg::aluOp_t exAluOp,
    output mipsPkg::word_t exOperandA,
    output mipsPkg::word_t exOperandB,
    output mipsPkg::word_t exImmediate,
    output mipsPkg::word_t exPcPlusFour,
    output mipsPkg::regAddr_t exRs,
    output mipsPkg::regAddr_t exRt,
    output mipsPkg::regAddr_t exDest
);
    import mipsPkg::*;

    opcode_t opcode;
    funct_t funct;
    regAddr_t rs, rt, rd;
    word_t immediate, readA, readB;
    word_t regFile [32];
    logic regWrite, regDst, memRead, memWrite, branch, branchNot, aluSrc;
    aluOp_t aluOp;
    logic bubble;

    // instruction fields
    assign opcode = idInstruction[31:26];
    assign rs = idInstruction[25:21];
    assign rt = idInstruction[20:16];
    assign rd = idInstruction[15:11];
    assign funct = idInstruction[5:0];
    assign immediate = {{16{idInstruction[15]}}, idInstruction[15:0]};

    ////////////////////
    // opcode decoder
    always_comb begin
        regWrite = 1'b0;
        regDst = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        branch = 1'b0;
        branchNot = 1'b0;
        aluSrc = 1'b0;
        aluOp = AluOpMem;
        case (opcode)
            OpRType: begin
                regDst = 1'b1;
                aluOp = AluOpRType;
                // sll and other unknown functs write nothing
                regWrite = funct inside {FunctAdd, FunctSub, FunctAnd, FunctOr, FunctSlt};
            end
            OpBeq: begin
                branch = 1'b1;
                aluOp = AluOpBranch;
            end
            OpBne: begin
                branchNot = 1'b1;
                aluOp = AluOpBranch;
            end
            OpLw: begin
                regWrite = 1'b1;
                memRead = 1'b1;
                aluSrc = 1'b1;
            end
            OpSw: begin
                memWrite = 1'b1;
                aluSrc = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////
    // register file, r0 never written
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            for (int i = 0; i < 32; i++) regFile[i] <= '0;
        end else if (wbRegWrite && wbWriteAddress != '0) begin
            regFile[wbWriteAddress] <= wbData;
        end
    end

    // write-through from write-back in the same cycle
    function automatic word_t readReg(input regAddr_t addr);
        if (wbRegWrite && wbWriteAddress != '0 && wbWriteAddress == addr) return wbData;
        return regFile[addr];
    endfunction

    always_comb begin
        readA = readReg(rs);
        readB = readReg(rt);
    end

    // load-use hazard against the load in execute
    assign stall = exMemRead && (exRt == rs || exRt == rt);
    assign bubble = stall || flush;

    ////////////////////
    // ID/EX register, write bits dropped on a bubble
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            exRegWrite <= 1'b0;
            exMemRead <= 1'b0;
            exMemWrite <= 1'b0;
            exBranch <= 1'b0;
            exBranchNot <= 1'b0;
            exAluSrc <= 1'b0;
            exAluOp <= AluOpMem;
        end else begin
            exRegWrite <= regWrite && !bubble;
            exMemRead <= memRead && !bubble;
            exMemWrite <= memWrite && !bubble;
            exBranch <= branch && !bubble;
            exBranchNot <= branchNot && !bubble;
            exAluSrc <= aluSrc;
            exAluOp <= aluOp;
        end
    end

    always_ff @(posedge clock) begin
        exOperandA <= readA;
        exOperandB <= readB;
        exImmediate <= immediate;
        exPcPlusFour <= idPcPlusFour;
        exRs <= rs;
        exRt <= rt;
        exDest <= regDst ? rd : rt;
    end

endmodule

`default_nettype wire

//--- execute/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage (
    input wire clock,
    input wire WriteEnable,
    input wire exRegWrite,
    input wire exMemRead,
    input wire exMemWrite,
    input wire exBranch,
    input wire exBranchNot,
    input wire exAluSrc,
    input wire mipsPkg::aluOp_t exAluOp,
    input wire mipsPkg::word_t exOperandA,
    input wire mipsPkg::word_t exOperandB,
    input wire mipsPkg::word_t exImmediate,
    input wire mipsPkg::word_t exPcPlusFour,
    input wire mipsPkg::regAddr_t exRs,
    input wire mipsPkg::regAddr_t exRt,
    input wire mipsPkg::regAddr_t exDest,
    input wire wbRegWrite,
    input wire mipsPkg::regAddr_t wbWriteAddress,
    input wire mipsPkg::word_t wbData,
    output logic branchTaken,
    output mipsPkg::word_t branchTarget,
    output logic flush,
    output logic memRegWrite,
    output logic memMemRead,
    output logic memMemWrite,
    output mipsPkg::regAddr_t memWriteAddress,
    output mipsPkg::word_t memAluResult,
    output mipsPkg::word_t memStoreData
);
    import mipsPkg::*;

    forwardSel_t forwardA, forwardB;
    word_t srcA, srcB, aluB, aluResult;
    aluCtrl_t aluCtrl;
    funct_t funct;
    logic zero;

    ////////////////////
    // forwarding, memory stage has priority over write-back
    function automatic forwardSel_t pickSource(input regAddr_t src);
        if (memRegWrite && memWriteAddress != '0 && memWriteAddress == src) return FwdMem;
        if (wbRegWrite && wbWriteAddress != '0 && wbWriteAddress == src) return FwdWb;
        return FwdReg;
    endfunction

    function automatic word_t applySource(input forwardSel_t sel, input word_t regValue);
        case (sel)
            FwdMem: return memAluResult;
            FwdWb: return wbData;
            default: return regValue;
        endcase
    endfunction

    always_comb begin
        forwardA = pickSource(exRs);
        forwardB = pickSource(exRt);
        srcA = applySource(forwardA, exOperandA);
        srcB = applySource(forwardB, exOperandB);
    end

    assign aluB = exAluSrc ? exImmediate : srcB;
    // function code rides in the low immediate bits
    assign funct = exImmediate[5:0];

    // ALU control
    always_comb begin
        case (exAluOp)
            AluOpMem: aluCtrl = AluAdd;
            AluOpBranch: aluCtrl = AluSub;
            AluOpRType:
                case (funct)
                    FunctSub: aluCtrl = AluSub;
                    FunctAnd: aluCtrl = AluAnd;
                    FunctOr: aluCtrl = AluOr;
                    FunctSlt: aluCtrl = AluSlt;
                    default: aluCtrl = AluAdd;
                endcase
            default: aluCtrl = AluAdd;
        endcase
    end

    // ALU, slt compares signed
    always_comb begin
        case (aluCtrl)
            AluAnd: aluResult = srcA & aluB;
            AluOr: aluResult = srcA | aluB;
            AluSub: aluResult = srcA - aluB;
            AluSlt: aluResult = {31'd0, $signed(srcA) < $signed(aluB)};
            default: aluResult = srcA + aluB;
        endcase
    end

    ////////////////////
    // branch resolves here
    assign zero = (aluResult == '0);
    assign branchTaken = (exBranch && zero) || (exBranchNot && !zero);
    assign branchTarget = exPcPlusFour + {exImmediate[29:0], 2'b00};
    assign flush = branchTaken;

    // EX/MEM register
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            memRegWrite <= 1'b0;
            memMemRead <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clock) begin
        memWriteAddress <= exDest;
        memAluResult <= aluResult;
        memStoreData <= srcB;
    end

endmodule

`default_nettype wire

//--- fetch/fetchStage.sv
`timescale 1ns/100ps
`default_nettype none

module fetchStage (
    input wire clock,
    input wire WriteEnable,
    input wire run,
    input wire stall,
    input wire branchTaken,
    input wire mipsPkg::word_t branchTarget,
    input wire instrWrite,
    input wire [mipsPkg::InstrAddrBits-1:0] writeIndex,
    input wire mipsPkg::word_t writeWord,
    output mipsPkg::word_t idInstruction,
    output mipsPkg::word_t idPcPlusFour
);
    import mipsPkg::*;

    word_t instrMem [InstrDepth];
    word_t pc;
    word_t pcPlusFour;
    word_t fetched;

    // filled only through the load port
    always_ff @(posedge clock) begin
        if (instrWrite) begin
            instrMem[writeIndex] <= writeWord;
        end
    end

    assign pcPlusFour = pc + 32'd4;
    // halted core sees zero words, decoded as nop
    assign fetched = run ? instrMem[pc[InstrAddrBits+1:2]] : '0;

    ////////////////////
    // program counter
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (branchTaken) begin
            // redirect wins over a stall in decode
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pcPlusFour;
        end
    end

    ////////////////////
    // IF/ID register
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            idInstruction <= '0;
            idPcPlusFour <= '0;
        end else if (branchTaken) begin
            // squash the wrong-path fetch
            idInstruction <= '0;
            idPcPlusFour <= '0;
        end else if (!stall) begin
            idInstruction <= fetched;
            idPcPlusFour <= pcPlusFour;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
common/mipsPkg.sv
verilog/loadPort.sv
fetch/fetchStage.sv
decode/decodeStage.sv
execute/executeStage.sv
verilog/memoryWriteback.sv
verilog/mipsCore.sv
testbench/mipsCore_chk.sv
testbench/mipsCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log
verilator --binary --assert --top-module mipsCoreTb -f flist.f -o mipsSim \
    && ./obj_dir/mipsSim > sim.log 2>&1 \
    || { echo "build or simulation aborted"; exit 1; }
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

//--- testbench/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb;
    import mipsPkg::*;

    localparam int DataCount = 8;
    localparam int LoadTimeout = 10;
    localparam int RetireTimeout = 100;
    localparam int QuietCycles = 30;

    logic clock;
    logic WriteEnable;
    logic run;
    logic loadReq;
    logic loadTarget;
    logic [InstrAddrBits-1:0] loadAddress;
    word_t loadWord;
    logic loadAck;
    logic retireValid;
    regAddr_t retireAddress;
    word_t retireData;

    // program table with names, random data words
    word_t progWord [$];
    string progName [$];
    word_t dataWord [DataCount];
    // expected retires in order
    regAddr_t expAddr [$];
    word_t expData [$];

    int checkCount;
    int errorCount;

    mipsCore UUT (.clock, .WriteEnable, .run, .loadReq, .loadTarget, .loadAddress,
        .loadWord, .loadAck, .retireValid, .retireAddress, .retireData);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////
    // helpers
    task automatic checkValue(input string testName, input word_t expected, input word_t actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("** Error %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    function automatic word_t encodeR(funct_t fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        return {OpRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encodeI(opcode_t op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addInstr(input word_t word, input string name);
        progWord.push_back(word);
        progName.push_back(name);
    endtask

    task automatic buildProgram();
        // random words into r1..r4
        addInstr(encodeI(OpLw, 5'd1, 5'd0, 16'd0), "lw r1,0(r0)");
        addInstr(encodeI(OpLw, 5'd2, 5'd0, 16'd4), "lw r2,4(r0)");
        addInstr(encodeI(OpLw, 5'd3, 5'd0, 16'd8), "lw r3,8(r0)");
        addInstr(encodeI(OpLw, 5'd4, 5'd0, 16'd12), "lw r4,12(r0)");
        // back to back, operands from MEM and WB
        addInstr(encodeR(FunctAdd, 5'd5, 5'd1, 5'd2), "add r5,r1,r2");
        addInstr(encodeR(FunctSub, 5'd6, 5'd5, 5'd3), "sub r6,r5,r3");
        addInstr(encodeR(FunctAnd, 5'd7, 5'd5, 5'd6), "and r7,r5,r6");
        addInstr(encodeR(FunctOr, 5'd8, 5'd7, 5'd4), "or r8,r7,r4");
        addInstr(encodeR(FunctSlt, 5'd9, 5'd6, 5'd8), "slt r9,r6,r8");
        addInstr(encodeR(FunctSlt, 5'd10, 5'd8, 5'd6), "slt r10,r8,r6");
        // load-use pair
        addInstr(encodeI(OpLw, 5'd11, 5'd0, 16'd16), "lw r11,16(r0)");
        addInstr(encodeR(FunctAdd, 5'd12, 5'd11, 5'd1), "add r12,r11,r1");
        // store then reload the same word
        addInstr(encodeI(OpSw, 5'd12, 5'd0, 16'd32), "sw r12,32(r0)");
        addInstr(encodeI(OpLw, 5'd13, 5'd0, 16'd32), "lw r13,32(r0)");
        addInstr(encodeR(FunctAdd, 5'd14, 5'd13, 5'd13), "add r14,r13,r13");
        // taken beq over two
        addInstr(encodeI(OpBeq, 5'd1, 5'd1, 16'd2), "beq r1,r1,+2");
        addInstr(encodeR(FunctAdd, 5'd15, 5'd1, 5'd1), "add r15,r1,r1");
        addInstr(encodeR(FunctOr, 5'd16, 5'd1, 5'd2), "or r16,r1,r2");
        // not taken
        addInstr(encodeI(OpBne, 5'd0, 5'd0, 16'd1), "bne r0,r0,+1");
        addInstr(encodeR(FunctAdd, 5'd17, 5'd2, 5'd3), "add r17,r2,r3");
        // taken bne, r1 is odd so never zero
        addInstr(encodeI(OpBne, 5'd0, 5'd1, 16'd1), "bne r1,r0,+1");
        addInstr(encodeR(FunctAdd, 5'd18, 5'd1, 5'd1), "add r18,r1,r1");
        addInstr(encodeR(FunctAdd, 5'd0, 5'd1, 5'd2), "add r0,r1,r2");
        addInstr(encodeI(OpLw, 5'd19, 5'd0, 16'd20), "lw r19,20(r0)");
        addInstr(encodeI(OpLw, 5'd20, 5'd0, 16'd28), "lw r20,28(r0)");
        addInstr(encodeR(FunctAnd, 5'd21, 5'd19, 5'd20), "and r21,r19,r20");
        // park here
        addInstr(encodeI(OpBeq, 5'd0, 5'd0, 16'hFFFF), "beq r0,r0,-1");
        addInstr('0, "nop");
        addInstr('0, "nop");
    endtask

    ////////////////////
    // sequential ISA model, one instruction at a time
    task automatic modelProgram();
        word_t regs [32];
        word_t mem [DataDepth];
        word_t instr, a, b, imm, addr, result;
        regAddr_t rs, rt, rd;
        int pc, nextPc, steps, idx;
        logic done, writes, taken;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < DataDepth; i++) mem[i] = '0;
        for (int i = 0; i < DataCount; i++) mem[i] = dataWord[i];
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 1000 && pc < progWord.size()) begin
            instr = progWord[pc];
            rs = instr[25:21];
            rt = instr[20:16];
            rd = instr[15:11];
            imm = {{16{instr[15]}}, instr[15:0]};
            a = regs[rs];
            b = regs[rt];
            addr = a + imm;
            idx = int'(addr[DataAddrBits+1:2]);
            nextPc = pc + 1;
            writes = 1'b0;
            result = '0;
            case (instr[31:26])
                OpRType: begin
                    writes = 1'b1;
                    case (instr[5:0])
                        FunctAdd: result = a + b;
                        FunctSub: result = a - b;
                        FunctAnd: result = a & b;
                        FunctOr: result = a | b;
                        FunctSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                    // destination is rd
                    rt = rd;
                end
                OpLw: begin
                    writes = 1'b1;
                    result = mem[idx];
                end
                OpSw: mem[idx] = b;
                OpBeq, OpBne: begin
                    taken = (instr[31:26] == OpBeq) ? (a == b) : (a != b);
                    if (taken) nextPc = pc + 1 + int'($signed(instr[15:0]));
                    // branch onto itself ends the program
                    if (taken && nextPc == pc) done = 1'b1;
                end
                default: ;
            endcase
            if (writes && rt != '0) begin
                regs[rt] = result;
                expAddr.push_back(rt);
                expData.push_back(result);
            end
            pc = nextPc;
            steps++;
        end
    endtask

    ////////////////////
    // one four-phase load transaction
    task automatic loadOne(input logic target, input logic [InstrAddrBits-1:0] index,
        input word_t word, input string name);
        int waited;
        @(posedge clock);
        loadReq <= 1'b1;
        loadTarget <= target;
        loadAddress <= index;
        loadWord <= word;
        waited = 0;
        @(negedge clock);
        while (!loadAck && waited < LoadTimeout) begin
            @(negedge clock);
            waited++;
        end
        if (!loadAck) begin
            errorCount++;
            $display("no acknowledge for load of %s within %0d cycles", name, LoadTimeout);
        end else begin
            checkCount++;
        end
        @(posedge clock);
        loadReq <= 1'b0;
        waited = 0;
        @(negedge clock);
        while (loadAck && waited < LoadTimeout) begin
            @(negedge clock);
            waited++;
        end
        if (loadAck) begin
            errorCount++;
            $display("acknowledge for load of %s never dropped", name);
        end else begin
            checkCount++;
        end
    endtask

    // nothing may retire while halted
    always @(negedge clock) begin
        if (!WriteEnable && !run && retireValid) begin
            errorCount++;
            $display("retire of r%0d seen while the core was halted", retireAddress);
        end
    end

    ////////////////////
    // main sequence
    initial begin
        int waited;
        int extra;
        WriteEnable <= 1'b1;
        run <= 1'b0;
        loadReq <= 1'b0;
        loadTarget <= 1'b0;
        loadAddress <= '0;
        loadWord <= '0;
        checkCount = 0;
        errorCount = 0;
        void'($urandom(94697));
        // odd words keep r1 nonzero
        for (int i = 0; i < DataCount; i++) dataWord[i] = $urandom() | 32'd1;
        buildProgram();
        modelProgram();
        repeat (16) @(posedge clock);
        WriteEnable <= 1'b0;

        for (int i = 0; i < progWord.size(); i++) begin
            loadOne(1'b0, InstrAddrBits'(i), progWord[i], progName[i]);
        end
        for (int i = 0; i < DataCount; i++) begin
            loadOne(1'b1, InstrAddrBits'(i), dataWord[i], $sformatf("data %0d", i));
        end

        @(posedge clock);
        run <= 1'b1;
        for (int k = 0; k < expAddr.size(); k++) begin
            waited = 0;
            @(negedge clock);
            while (!retireValid && waited < RetireTimeout) begin
                @(negedge clock);
                waited++;
            end
            if (!retireValid) begin
                errorCount++;
                $display("retire %0d of %0d never arrived", k, expAddr.size());
                break;
            end
            checkValue($sformatf("retire %0d address", k), {27'd0, expAddr[k]},
                {27'd0, retireAddress});
            checkValue($sformatf("retire %0d data", k), expData[k], retireData);
        end

        // no stray retire afterwards
        extra = 0;
        for (int c = 0; c < QuietCycles; c++) begin
            @(negedge clock);
            if (retireValid) extra++;
        end
        if (extra != 0) begin
            errorCount++;
            $display("%0d retires arrived after the last expected one", extra);
        end

        $display("checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mipsCore_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore_chk (
    input wire clock,
    input wire WriteEnable,
    input wire run,
    input wire loadReq,
    input wire loadAck,
    input wire retireValid
);

    ////////////////////
    // load port handshake

    // ack released once req has been low for two samples
    ackReleased: assert property (@(posedge clock) disable iff (WriteEnable)
        (!loadReq && $past(!loadReq)) |-> !loadAck)
        else $error("loadAck still high after loadReq was low for two cycles");

    // ack only ever answers a request
    ackAnswersReq: assert property (@(posedge clock) disable iff (WriteEnable)
        $rose(loadAck) |-> loadReq)
        else $error("loadAck rose without loadReq");

    ////////////////////
    // a retire needs run high at its fetch four cycles earlier
    retireAfterRun: assert property (@(posedge clock) disable iff (WriteEnable)
        retireValid |-> $past(run, 4))
        else $error("retire event without run high at fetch time");

endmodule

bind mipsCore mipsCore_chk handshakeChk (
    .clock(clock),
    .WriteEnable(WriteEnable),
    .run(run),
    .loadReq(loadReq),
    .loadAck(loadAck),
    .retireValid(retireValid)
);

`default_nettype wire

//--- verilog/loadPort.sv
`timescale 1ns/100ps
`default_nettype none

module loadPort (
    input wire clock,
    input wire WriteEnable,
    input wire loadReq,
    input wire loadTarget,
    input wire [mipsPkg::InstrAddrBits-1:0] loadAddress,
    input wire mipsPkg::word_t loadWord,
    output logic loadAck,
    output logic instrWrite,
    output logic dataWrite,
    output logic [mipsPkg::InstrAddrBits-1:0] writeIndex,
    output mipsPkg::word_t writeWord
);
    import mipsPkg::*;

    loadState_t state;
    // 1 selects data memory
    logic targetData;

    // four-phase slave FSM
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            state <= LoadIdle;
        end else begin
            case (state)
                LoadIdle:
                    if (loadReq) state <= LoadWrite;
                // strobe fires in this state, one cycle
                LoadWrite:
                    state <= LoadAck;
                // hold ack until the master lets go
                LoadAck:
                    if (!loadReq) state <= LoadIdle;
                default:
                    state <= LoadIdle;
            endcase
        end
    end

    // capture the transaction when accepted
    always_ff @(posedge clock) begin
        if (state == LoadIdle && loadReq) begin
            targetData <= loadTarget;
            writeIndex <= loadAddress;
            writeWord <= loadWord;
        end
    end

    assign instrWrite = (state == LoadWrite) && !targetData;
    assign dataWrite = (state == LoadWrite) && targetData;
    assign loadAck = (state == LoadAck);

endmodule

`default_nettype wire

//--- verilog/memoryWriteback.sv
`timescale 1ns/100ps
`default_nettype none

module memoryWriteback (
    input wire clock,
    input wire WriteEnable,
    input wire memRegWrite,
    input wire memMemRead,
    input wire memMemWrite,
    input wire mipsPkg::regAddr_t memWriteAddress,
    input wire mipsPkg::word_t memAluResult,
    input wire mipsPkg::word_t memStoreData,
    input wire dataWrite,
    input wire [mipsPkg::DataAddrBits-1:0] writeIndex,
    input wire mipsPkg::word_t writeWord,
    output logic wbRegWrite,
    output mipsPkg::regAddr_t wbWriteAddress,
    output mipsPkg::word_t wbData
);
    import mipsPkg::*;

    word_t dataMem [DataDepth];
    word_t readData;
    logic [DataAddrBits-1:0] memIndex;

    // byte address to word index
    assign memIndex = memAluResult[DataAddrBits+1:2];
    assign readData = dataMem[memIndex];

    ////////////////////
    // data memory, load port only while halted
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            for (int i = 0; i < DataDepth; i++) dataMem[i] <= '0;
        end else if (dataWrite) begin
            dataMem[writeIndex] <= writeWord;
        end else if (memMemWrite) begin
            dataMem[memIndex] <= memStoreData;
        end
    end

    // MEM/WB register, write-back select ahead of it
    always_ff @(posedge clock or posedge WriteEnable) begin
        if (WriteEnable) begin
            wbRegWrite <= 1'b0;
        end else begin
            wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge clock) begin
        wbWriteAddress <= memWriteAddress;
        wbData <= memMemRead ? readData : memAluResult;
    end

endmodule

`default_nettype wire

//--- verilog/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
    input wire clock,
    input wire WriteEnable,
    input wire run,
    input wire loadReq,
    input wire loadTarget,
    input wire [mipsPkg::InstrAddrBits-1:0] loadAddress,
    input wire mipsPkg::word_t loadWord,
    output logic loadAck,
    output logic retireValid,
    output mipsPkg::regAddr_t retireAddress,
    output mipsPkg::word_t retireData
);
    import mipsPkg::*;

    // load port to memories
    logic instrWrite, dataWrite;
    logic [InstrAddrBits-1:0] writeIndex;
    word_t writeWord;
    // fetch and decode
    word_t idInstruction, idPcPlusFour;
    logic stall, flush, branchTaken;
    word_t branchTarget;
    // ID/EX
    logic exRegWrite, exMemRead, exMemWrite, exBranch, exBranchNot, exAluSrc;
    aluOp_t exAluOp;
    word_t exOperandA, exOperandB, exImmediate, exPcPlusFour;
    regAddr_t exRs, exRt, exDest;
    // EX/MEM and MEM/WB
    logic memRegWrite, memMemRead, memMemWrite, wbRegWrite;
    regAddr_t memWriteAddress, wbWriteAddress;
    word_t memAluResult, memStoreData, wbData;

    loadPort loader (.clock, .WriteEnable, .loadReq, .loadTarget, .loadAddress, .loadWord,
        .loadAck, .instrWrite, .dataWrite, .writeIndex, .writeWord);

    fetchStage fetch (.clock, .WriteEnable, .run, .stall, .branchTaken, .branchTarget,
        .instrWrite, .writeIndex, .writeWord, .idInstruction, .idPcPlusFour);

    decodeStage decode (.clock, .WriteEnable, .idInstruction, .idPcPlusFour, .flush,
        .wbRegWrite, .wbWriteAddress, .wbData, .stall, .exRegWrite, .exMemRead,
        .exMemWrite, .exBranch, .exBranchNot, .exAluSrc, .exAluOp, .exOperandA,
        .exOperandB, .exImmediate, .exPcPlusFour, .exRs, .exRt, .exDest);

    executeStage execute (.clock, .WriteEnable, .exRegWrite, .exMemRead, .exMemWrite,
        .exBranch, .exBranchNot, .exAluSrc, .exAluOp, .exOperandA, .exOperandB,
        .exImmediate, .exPcPlusFour, .exRs, .exRt, .exDest, .wbRegWrite, .wbWriteAddress,
        .wbData, .branchTaken, .branchTarget, .flush, .memRegWrite, .memMemRead,
        .memMemWrite, .memWriteAddress, .memAluResult, .memStoreData);

    memoryWriteback memWb (.clock, .WriteEnable, .memRegWrite, .memMemRead, .memMemWrite,
        .memWriteAddress, .memAluResult, .memStoreData, .dataWrite, .writeIndex,
        .writeWord, .wbRegWrite, .wbWriteAddress, .wbData);

    // retire event, writes to r0 are invisible
    assign retireValid = wbRegWrite && (wbWriteAddress != '0);
    assign retireAddress = wbWriteAddress;
    assign retireData = wbData;

endmodule

`default_nettype wire
